// ==== hdl/cpu_types_pkg.sv ====
package cpu_types_pkg;

  // Integer ISA widths
  localparam int REG_ADDR_W = 5;
  localparam int XLEN       = 32;
  localparam int NUM_REGS   = 32;

  // Register index into the 32-entry file
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // One register value
  typedef logic [XLEN-1:0] reg_data_t;

  // Hardwired zero register, never written
  localparam reg_addr_t ZERO_REG = '0;

endpackage

// ==== hdl/forwarding_pkg.sv ====
package forwarding_pkg;

  import cpu_types_pkg::*;

  // One lane's read request as it enters the stage
  typedef struct packed {
    logic      rden1;
    reg_addr_t raddr1;
    logic      rden2;
    reg_addr_t raddr2;
  } read_req_type;

  // Read request together with the raw register file data
  typedef struct packed {
    logic      rden1;
    reg_addr_t raddr1;
    reg_data_t rdata1;
    logic      rden2;
    reg_addr_t raddr2;
    reg_data_t rdata2;
  } forwarding_register_in_type;

  typedef struct packed {
    logic      wren;
    reg_addr_t waddr;
    reg_data_t wdata;
  } exec_result_type;

  typedef struct packed {
    logic      wren;
    reg_addr_t waddr;
    reg_data_t wdata;
  } forwarding_memory_in_type;

  typedef struct packed {
    logic      wren;
    reg_addr_t waddr;
    reg_data_t wdata;
  } forwarding_writeback_in_type;

  // Final operands of one lane
  typedef struct packed {
    reg_data_t data1;
    reg_data_t data2;
  } forwarding_out_type;

endpackage

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  cpu_types_pkg::reg_addr_t                  raddr0_1,
  input  cpu_types_pkg::reg_addr_t                  raddr0_2,
  input  cpu_types_pkg::reg_addr_t                  raddr1_1,
  input  cpu_types_pkg::reg_addr_t                  raddr1_2,
  output cpu_types_pkg::reg_data_t                  rdata0_1,
  output cpu_types_pkg::reg_data_t                  rdata0_2,
  output cpu_types_pkg::reg_data_t                  rdata1_1,
  output cpu_types_pkg::reg_data_t                  rdata1_2,
  input  forwarding_pkg::forwarding_writeback_in_type wb0,
  input  forwarding_pkg::forwarding_writeback_in_type wb1
);

  import cpu_types_pkg::*;

  reg_data_t regs [NUM_REGS];

  // Four independent read ports, old value until the edge
  assign rdata0_1 = regs[raddr0_1];
  assign rdata0_2 = regs[raddr0_2];
  assign rdata1_1 = regs[raddr1_1];
  assign rdata1_2 = regs[raddr1_2];

  // Two write ports, lane 1 is applied last so it wins a shared address
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wb0.wren) begin
        regs[wb0.waddr] <= wb0.wdata;
      end
      if (wb1.wren) begin
        regs[wb1.waddr] <= wb1.wdata;  // Overrides lane 0
      end
    end
  end

endmodule

// ==== hdl/result_pipe.sv ====
`timescale 1ns/1ps

module result_pipe (
  input  logic                                        clk,
  input  logic                                        rst_n,
  input  forwarding_pkg::exec_result_type             exec0_res,
  input  forwarding_pkg::exec_result_type             exec1_res,
  output forwarding_pkg::forwarding_memory_in_type    mem0,
  output forwarding_pkg::forwarding_memory_in_type    mem1,
  output forwarding_pkg::forwarding_writeback_in_type wb0,
  output forwarding_pkg::forwarding_writeback_in_type wb1
);

  import cpu_types_pkg::*;
  import forwarding_pkg::*;

  exec_result_type exec_res [2];

  logic [1:0] mem_wren;
  logic [1:0] wb_wren;
  reg_addr_t  mem_waddr [2];
  reg_data_t  mem_wdata [2];
  reg_addr_t  wb_waddr  [2];
  reg_data_t  wb_wdata  [2];

  assign exec_res[0] = exec0_res;
  assign exec_res[1] = exec1_res;

  // Stage enables, cleared on reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wren <= '0;
      wb_wren  <= '0;
    end else begin
      for (int l = 0; l < 2; l++) begin
        // Writes to x0 are dropped here and nowhere else
        mem_wren[l] <= exec_res[l].wren && (exec_res[l].waddr != ZERO_REG);
      end
      wb_wren <= mem_wren;
    end
  end

  // Address and data just follow the pipe
  always_ff @(posedge clk) begin
    for (int l = 0; l < 2; l++) begin
      mem_waddr[l] <= exec_res[l].waddr;
      mem_wdata[l] <= exec_res[l].wdata;
      wb_waddr[l]  <= mem_waddr[l];
      wb_wdata[l]  <= mem_wdata[l];
    end
  end

  assign mem0 = '{wren: mem_wren[0], waddr: mem_waddr[0], wdata: mem_wdata[0]};
  assign mem1 = '{wren: mem_wren[1], waddr: mem_waddr[1], wdata: mem_wdata[1]};
  assign wb0  = '{wren: wb_wren[0], waddr: wb_waddr[0], wdata: wb_wdata[0]};
  assign wb1  = '{wren: wb_wren[1], waddr: wb_waddr[1], wdata: wb_wdata[1]};

endmodule

// ==== hdl/forwarding.sv ====
`timescale 1ns/1ps

module forwarding (
  input  forwarding_pkg::forwarding_register_in_type  forwarding0_rin,
  input  forwarding_pkg::forwarding_register_in_type  forwarding1_rin,
  input  forwarding_pkg::forwarding_memory_in_type    forwarding0_min,
  input  forwarding_pkg::forwarding_memory_in_type    forwarding1_min,
  input  forwarding_pkg::forwarding_writeback_in_type forwarding0_win,
  input  forwarding_pkg::forwarding_writeback_in_type forwarding1_win,
  output forwarding_pkg::forwarding_out_type          forwarding0_out,
  output forwarding_pkg::forwarding_out_type          forwarding1_out
);

  import cpu_types_pkg::*;
  import forwarding_pkg::*;

  // Picks the newest in-flight value for one source operand.
  // Later checks override earlier ones, so mem lane 1 has top priority.
  function automatic reg_data_t bypass(
    input logic                        rden,
    input reg_addr_t                   raddr,
    input reg_data_t                   rdata,
    input forwarding_memory_in_type    m0,
    input forwarding_memory_in_type    m1,
    input forwarding_writeback_in_type w0,
    input forwarding_writeback_in_type w1
  );
    reg_data_t res;
    res = '0;  // Disabled read
    if (rden) begin
      res = rdata;
      if (w0.wren && (w0.waddr == raddr)) begin
        res = w0.wdata;
      end
      if (w1.wren && (w1.waddr == raddr)) begin
        res = w1.wdata;
      end
      if (m0.wren && (m0.waddr == raddr)) begin
        res = m0.wdata;
      end
      if (m1.wren && (m1.waddr == raddr)) begin
        res = m1.wdata;  // Youngest result
      end
    end
    return res;
  endfunction

  assign forwarding0_out.data1 = bypass(forwarding0_rin.rden1, forwarding0_rin.raddr1,
                                        forwarding0_rin.rdata1,
                                        forwarding0_min, forwarding1_min,
                                        forwarding0_win, forwarding1_win);

  assign forwarding0_out.data2 = bypass(forwarding0_rin.rden2, forwarding0_rin.raddr2,
                                        forwarding0_rin.rdata2,
                                        forwarding0_min, forwarding1_min,
                                        forwarding0_win, forwarding1_win);

  assign forwarding1_out.data1 = bypass(forwarding1_rin.rden1, forwarding1_rin.raddr1,
                                        forwarding1_rin.rdata1,
                                        forwarding0_min, forwarding1_min,
                                        forwarding0_win, forwarding1_win);

  assign forwarding1_out.data2 = bypass(forwarding1_rin.rden2, forwarding1_rin.raddr2,
                                        forwarding1_rin.rdata2,
                                        forwarding0_min, forwarding1_min,
                                        forwarding0_win, forwarding1_win);

endmodule

// ==== hdl/operand_bypass.sv ====
`timescale 1ns/1ps

module operand_bypass (
  input  logic                               clk,
  input  logic                               rst_n,
  input  forwarding_pkg::read_req_type       issue0_req,
  input  forwarding_pkg::read_req_type       issue1_req,
  input  forwarding_pkg::exec_result_type    exec0_res,
  input  forwarding_pkg::exec_result_type    exec1_res,
  output forwarding_pkg::forwarding_out_type operand0,
  output forwarding_pkg::forwarding_out_type operand1
);

  import cpu_types_pkg::*;
  import forwarding_pkg::*;

  reg_data_t rdata0_1;
  reg_data_t rdata0_2;
  reg_data_t rdata1_1;
  reg_data_t rdata1_2;

  forwarding_register_in_type  rin0;
  forwarding_register_in_type  rin1;
  forwarding_memory_in_type    mem0;
  forwarding_memory_in_type    mem1;
  forwarding_writeback_in_type wb0;
  forwarding_writeback_in_type wb1;

  register_file regfile_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .raddr0_1 (issue0_req.raddr1),
    .raddr0_2 (issue0_req.raddr2),
    .raddr1_1 (issue1_req.raddr1),
    .raddr1_2 (issue1_req.raddr2),
    .rdata0_1 (rdata0_1),
    .rdata0_2 (rdata0_2),
    .rdata1_1 (rdata1_1),
    .rdata1_2 (rdata1_2),
    .wb0      (wb0),
    .wb1      (wb1)
  );

  result_pipe pipe_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .exec0_res (exec0_res),
    .exec1_res (exec1_res),
    .mem0      (mem0),
    .mem1      (mem1),
    .wb0       (wb0),
    .wb1       (wb1)
  );

  // Request plus raw file data per lane
  assign rin0 = '{rden1: issue0_req.rden1, raddr1: issue0_req.raddr1, rdata1: rdata0_1,
                  rden2: issue0_req.rden2, raddr2: issue0_req.raddr2, rdata2: rdata0_2};
  assign rin1 = '{rden1: issue1_req.rden1, raddr1: issue1_req.raddr1, rdata1: rdata1_1,
                  rden2: issue1_req.rden2, raddr2: issue1_req.raddr2, rdata2: rdata1_2};

  forwarding fwd_i (
    .forwarding0_rin (rin0),
    .forwarding1_rin (rin1),
    .forwarding0_min (mem0),
    .forwarding1_min (mem1),
    .forwarding0_win (wb0),
    .forwarding1_win (wb1),
    .forwarding0_out (operand0),
    .forwarding1_out (operand1)
  );

endmodule

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial clk = 1'b0;
  always #5 clk = ~clk;  // 10 ns period

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

// ==== verif/operand_bypass_assert.sv ====
`timescale 1ns/1ps

module operand_bypass_assert (
  input logic                                        clk,
  input logic                                        rst_n,
  input forwarding_pkg::read_req_type                issue0_req,
  input forwarding_pkg::read_req_type                issue1_req,
  input forwarding_pkg::forwarding_out_type          operand0,
  input forwarding_pkg::forwarding_out_type          operand1,
  input forwarding_pkg::forwarding_memory_in_type    mem0,
  input forwarding_pkg::forwarding_memory_in_type    mem1,
  input forwarding_pkg::forwarding_writeback_in_type wb0,
  input forwarding_pkg::forwarding_writeback_in_type wb1
);

  import cpu_types_pkg::*;

  logic [3:0] stage_wren;

  assign stage_wren = {mem0.wren, mem1.wren, wb0.wren, wb1.wren};

  disabled_read_zero: assert property (@(posedge clk) disable iff (!rst_n)
    (issue0_req.rden1 || operand0.data1 == '0) && (issue0_req.rden2 || operand0.data2 == '0) &&
    (issue1_req.rden1 || operand1.data1 == '0) && (issue1_req.rden2 || operand1.data2 == '0))
    else $error("Disabled read returned a nonzero operand");

  // x0 must be filtered before the memory stage
  no_zero_reg_enable: assert property (@(posedge clk) disable iff (!rst_n)
    !(mem0.wren && mem0.waddr == ZERO_REG) && !(mem1.wren && mem1.waddr == ZERO_REG) &&
    !(wb0.wren && wb0.waddr == ZERO_REG) && !(wb1.wren && wb1.waddr == ZERO_REG))
    else $error("Stage enable high with register 0 as target");

  stages_clear_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> stage_wren == '0)
    else $error("Stage enable high right after reset");

endmodule

bind operand_bypass operand_bypass_assert assert_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .issue0_req (issue0_req),
  .issue1_req (issue1_req),
  .operand0   (operand0),
  .operand1   (operand1),
  .mem0       (mem0),
  .mem1       (mem1),
  .wb0        (wb0),
  .wb1        (wb1)
);

// ==== verif/operand_bypass_tb.sv ====
`timescale 1ns/1ps

module operand_bypass_tb;

  import cpu_types_pkg::*;
  import forwarding_pkg::*;

  localparam int TIMEOUT_CYCLES = 3000;  // Six tests of up to 400 cycles plus margin
  localparam logic [31:0] SEED = 32'h481393ee;

  logic               clk;
  logic               rst_n;
  read_req_type       issue0_req;
  read_req_type       issue1_req;
  exec_result_type    exec0_res;
  exec_result_type    exec1_res;
  forwarding_out_type operand0;
  forwarding_out_type operand1;

  reg_data_t       model_regs [NUM_REGS];
  exec_result_type model_mem [2];  // In-flight results in the memory stage
  exec_result_type model_wb  [2];

  int errors;
  int checks;
  int err_base;
  int chk_base;
  int cycle_count;

  tb_clock_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

  operand_bypass dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .issue0_req (issue0_req),
    .issue1_req (issue1_req),
    .exec0_res  (exec0_res),
    .exec1_res  (exec1_res),
    .operand0   (operand0),
    .operand1   (operand1)
  );

  function automatic read_req_type make_req(input logic en1, input reg_addr_t a1,
                                            input logic en2, input reg_addr_t a2);
    read_req_type r;
    r.rden1  = en1;
    r.raddr1 = a1;
    r.rden2  = en2;
    r.raddr2 = a2;
    return r;
  endfunction

  function automatic exec_result_type make_res(input logic en, input reg_addr_t a,
                                               input reg_data_t d);
    exec_result_type r;
    r.wren  = en;
    r.waddr = a;
    r.wdata = d;
    return r;
  endfunction

  // Raw value overridden by wb0, wb1, mem0, mem1 in rising priority
  function automatic reg_data_t expect_operand(input logic rden, input reg_addr_t raddr);
    reg_data_t v;
    v = '0;
    if (rden) begin
      v = model_regs[raddr];
      for (int l = 0; l < 2; l++) begin
        if (model_wb[l].wren && model_wb[l].waddr == raddr) v = model_wb[l].wdata;
      end
      for (int l = 0; l < 2; l++) begin
        if (model_mem[l].wren && model_mem[l].waddr == raddr) v = model_mem[l].wdata;
      end
    end
    return v;
  endfunction

  task automatic check_operands(input string test, input forwarding_out_type exp,
                                input forwarding_out_type act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[FAIL] %s: expected %h actual %h", test, exp, act);
    end
  endtask

  // Compare this cycle and advance DUT and model on the same edge
  task automatic step(input string test);
    forwarding_out_type exp0;
    forwarding_out_type exp1;
    #1;
    exp0.data1 = expect_operand(issue0_req.rden1, issue0_req.raddr1);
    exp0.data2 = expect_operand(issue0_req.rden2, issue0_req.raddr2);
    exp1.data1 = expect_operand(issue1_req.rden1, issue1_req.raddr1);
    exp1.data2 = expect_operand(issue1_req.rden2, issue1_req.raddr2);
    check_operands(test, exp0, operand0);
    check_operands(test, exp1, operand1);
    @(posedge clk);
    for (int l = 0; l < 2; l++) begin
      if (model_wb[l].wren) model_regs[model_wb[l].waddr] = model_wb[l].wdata;  // Lane 1 last
    end
    for (int l = 0; l < 2; l++) begin
      model_wb[l] = model_mem[l];
    end
    model_mem[0] = exec0_res;
    model_mem[1] = exec1_res;
    for (int l = 0; l < 2; l++) begin
      if (model_mem[l].waddr == ZERO_REG) model_mem[l].wren = 1'b0;
    end
    #1;
  endtask

  task automatic quiet_results();
    exec0_res = '0;
    exec1_res = '0;
  endtask

  task automatic end_test(input string name);
    $display("Test %s: %0d checks, %0d errors", name, checks - chk_base, errors - err_base);
    chk_base = checks;
    err_base = errors;
  endtask

  task automatic reset_test();
    for (int a = 0; a < NUM_REGS; a++) begin
      issue0_req = make_req(1'b1, reg_addr_t'(a), a[0], reg_addr_t'(a + 1));
      issue1_req = make_req(a[1], reg_addr_t'(a + 2), 1'b1, reg_addr_t'(a + 3));
      step("reset");
    end
    end_test("reset");
  endtask

  task automatic regfile_test();
    issue0_req = '0;
    issue1_req = '0;
    for (int i = 1; i < NUM_REGS; i += 2) begin
      exec0_res = make_res(1'b1, reg_addr_t'(i), 32'hc0de_0000 + i);
      exec1_res = make_res(i + 1 < NUM_REGS, reg_addr_t'(i + 1), 32'h5eed_0000 + i + 1);
      step("regfile");
    end
    quiet_results();
    repeat (3) step("regfile");  // Drain the pipe
    for (int a = 0; a < NUM_REGS; a++) begin
      issue0_req = make_req(1'b1, reg_addr_t'(a), 1'b1, reg_addr_t'(a + 8));
      issue1_req = make_req(1'b1, reg_addr_t'(a + 16), 1'b1, reg_addr_t'(a + 24));
      step("regfile");
    end
    end_test("regfile");
  endtask

  task automatic stage_test();
    issue0_req = make_req(1'b1, 5'd5, 1'b1, 5'd7);
    issue1_req = make_req(1'b1, 5'd7, 1'b1, 5'd5);
    exec0_res = make_res(1'b1, 5'd5, 32'h1111_aaaa);
    step("stage");
    quiet_results();
    repeat (3) step("stage");  // Mem then wb then raw
    exec1_res = make_res(1'b1, 5'd7, 32'h2222_bbbb);
    step("stage");
    exec0_res = make_res(1'b1, 5'd7, 32'h3333_cccc);
    exec1_res = '0;
    step("stage");
    exec0_res = '0;
    repeat (4) step("stage");  // Mem value beats wb on r7
    end_test("stage");
  endtask

  task automatic lane_priority_test();
    issue0_req = make_req(1'b1, 5'd9, 1'b0, 5'd9);
    issue1_req = make_req(1'b1, 5'd9, 1'b1, 5'd9);
    exec0_res = make_res(1'b1, 5'd9, 32'h0000_0a0a);
    exec1_res = make_res(1'b1, 5'd9, 32'h0000_1b1b);
    step("lane_priority");
    quiet_results();
    repeat (4) step("lane_priority");
    end_test("lane_priority");
  endtask

  task automatic zero_test();
    issue0_req = make_req(1'b1, 5'd0, 1'b1, 5'd0);
    issue1_req = make_req(1'b1, 5'd0, 1'b1, 5'd3);
    exec0_res = make_res(1'b1, 5'd0, 32'hffff_ffff);
    exec1_res = make_res(1'b1, 5'd0, 32'hdead_beef);
    step("zero_reg");
    exec1_res = make_res(1'b1, 5'd3, 32'h0000_0033);
    step("zero_reg");
    quiet_results();
    repeat (4) step("zero_reg");
    end_test("zero_reg");
  endtask

  task automatic random_test();
    for (int n = 0; n < 300; n++) begin
      issue0_req = make_req(1'($urandom), reg_addr_t'($urandom_range(0, 7)),
                            1'($urandom), reg_addr_t'($urandom_range(0, 7)));
      issue1_req = make_req(1'($urandom), reg_addr_t'($urandom_range(0, 7)),
                            1'($urandom), reg_addr_t'($urandom_range(0, 7)));
      exec0_res = make_res(1'($urandom), reg_addr_t'($urandom_range(0, 7)), $urandom);
      exec1_res = make_res(1'($urandom), reg_addr_t'($urandom_range(0, 7)), $urandom);
      step("random");
    end
    end_test("random");
  endtask

  initial begin
    void'($urandom(SEED));
    errors = 0;
    checks = 0;
    err_base = 0;
    chk_base = 0;
    issue0_req = '0;
    issue1_req = '0;
    // Live results while in reset so the stage enables must be cleared by reset
    exec0_res = make_res(1'b1, 5'd1, 32'h0bad_0001);
    exec1_res = make_res(1'b1, 5'd2, 32'h0bad_0002);
    for (int r = 0; r < NUM_REGS; r++) model_regs[r] = '0;
    for (int l = 0; l < 2; l++) begin
      model_mem[l] = '0;
      model_wb[l]  = '0;
    end
    wait (rst_n === 1'b1);
    quiet_results();
    @(posedge clk);
    #1;
    reset_test();
    regfile_test();
    stage_test();
    lane_priority_test();
    zero_test();
    random_test();
    $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: tests did not finish within %0d cycles", cycle_count);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/cpu_types_pkg.sv
hdl/forwarding_pkg.sv
hdl/register_file.sv
hdl/result_pipe.sv
hdl/forwarding.sv
hdl/operand_bypass.sv
verif/tb_clock_gen.sv
verif/operand_bypass_assert.sv
verif/operand_bypass_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the operand bypass testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module operand_bypass_tb -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1
